/* hw/noc_flit_pkg.sv */
/*
 * noc flit format
 * header fields, payload width and the full flit layout
 */

`default_nettype none

package noc_flit_pkg;

  localparam int HdrWidth     = 8;
  localparam int PayloadWidth = 24;
  localparam int FlitWidth    = HdrWidth + PayloadWidth;

  typedef struct packed {
    logic [3:0] dst;
    logic [3:0] tag;
  } hdr_t;

  typedef logic [PayloadWidth-1:0] payload_t;

  // header sits in the upper bits
  typedef struct packed {
    hdr_t     hdr;
    payload_t payload;
  } flit_t;

endpackage

`default_nettype wire

/* hw/vc_router_pkg.sv */
/*
 * router configuration
 * virtual channel count and buffer sizing
 */

`default_nettype none

package vc_router_pkg;

  localparam int NumVC     = 4;
  localparam int VcIdWidth = 2;

  // same depth for local buffers and the downstream ones
  localparam int VcDepth     = 3;
  localparam int CreditWidth = 2;

endpackage

`default_nettype wire

/* hw/vc_fifo.sv */
/*
 * vc_fifo
 * small synchronous circular buffer with fall-through head,
 * pushes when full and pops when empty are dropped
 */

`timescale 1ns/1ps
`default_nettype none

module vc_fifo #(
  parameter type data_t = logic [7:0],
  parameter int  Depth  = 2
) (
  input  wire logic  clk_i,
  input  wire logic  reset_i,
  input  wire logic  push_i,
  input  wire data_t data_i,
  input  wire logic  pop_i,
  output data_t      data_o,
  output logic       valid_o
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  data_t                mem [Depth];
  logic  [PtrWidth-1:0] wr_ptr_q;
  logic  [PtrWidth-1:0] rd_ptr_q;
  logic  [CntWidth-1:0] count_q;
  logic                 do_push;
  logic                 do_pop;

  assign valid_o = (count_q != '0);
  assign data_o  = mem[rd_ptr_q];

  assign do_push = push_i && (count_q != CntWidth'(Depth));
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* hw/vc_input_port.sv */
/*
 * vc_input_port
 * per-VC header and payload buffers, header leaves at SA,
 * payload leaves at ST and each ST pop returns a credit upstream
 */

`timescale 1ns/1ps
`default_nettype none

module vc_input_port (
  input  wire logic                                                   clk_i,
  input  wire logic                                                   reset_i,
  // from the upstream router
  input  wire logic                      [vc_router_pkg::NumVC-1:0]   flit_v_i,
  input  wire noc_flit_pkg::flit_t                                    flit_i,
  // header pop from switch allocation
  input  wire logic                                                   sa_pop_v_i,
  input  wire logic                      [vc_router_pkg::VcIdWidth-1:0] sa_vc_i,
  // payload pop from switch traversal
  input  wire logic                                                   st_pop_v_i,
  input  wire logic                      [vc_router_pkg::VcIdWidth-1:0] st_vc_i,
  output logic                           [vc_router_pkg::NumVC-1:0]   hdr_head_v_o,
  output noc_flit_pkg::hdr_t             [vc_router_pkg::NumVC-1:0]   hdr_head_o,
  output noc_flit_pkg::payload_t         [vc_router_pkg::NumVC-1:0]   payload_head_o,
  // credit back to the upstream router
  output logic                                                        credit_v_o,
  output logic                           [vc_router_pkg::VcIdWidth-1:0] credit_vc_o
);

  logic [vc_router_pkg::NumVC-1:0] hdr_pop;
  logic [vc_router_pkg::NumVC-1:0] payload_pop;

  always_comb begin
    hdr_pop              = '0;
    hdr_pop[sa_vc_i]     = sa_pop_v_i;
    payload_pop          = '0;
    payload_pop[st_vc_i] = st_pop_v_i;
  end

  for (genvar v = 0; v < vc_router_pkg::NumVC; v++) begin : gen_vc
    vc_fifo #(
      .data_t (noc_flit_pkg::hdr_t),
      .Depth  (vc_router_pkg::VcDepth)
    ) u_hdr_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (flit_v_i[v]),
      .data_i  (flit_i.hdr),
      .pop_i   (hdr_pop[v]),
      .data_o  (hdr_head_o[v]),
      .valid_o (hdr_head_v_o[v])
    );

    // payload is present whenever the header is, so its valid goes unused
    vc_fifo #(
      .data_t (noc_flit_pkg::payload_t),
      .Depth  (vc_router_pkg::VcDepth)
    ) u_payload_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (flit_v_i[v]),
      .data_i  (flit_i.payload),
      .pop_i   (payload_pop[v]),
      .data_o  (payload_head_o[v]),
      .valid_o ()
    );
  end

  // buffer slot is free once the payload leaves
  assign credit_v_o  = st_pop_v_i;
  assign credit_vc_o = st_vc_i;

endmodule

`default_nettype wire

/* hw/switch_alloc.sv */
/*
 * switch_alloc
 * round-robin pick among VCs holding a header and a downstream
 * credit, grant is registered as the switch traversal stage
 */

`timescale 1ns/1ps
`default_nettype none

module switch_alloc (
  input  wire logic                                               clk_i,
  input  wire logic                                               reset_i,
  input  wire logic                  [vc_router_pkg::NumVC-1:0]   hdr_head_v_i,
  input  wire noc_flit_pkg::hdr_t    [vc_router_pkg::NumVC-1:0]   hdr_head_i,
  input  wire logic                  [vc_router_pkg::NumVC-1:0]   credit_avail_i,
  // SA grant, pops the header this cycle
  output logic                                                    sa_pop_v_o,
  output logic                       [vc_router_pkg::VcIdWidth-1:0] sa_vc_o,
  // ST stage
  output logic                                                    st_pop_v_o,
  output logic                       [vc_router_pkg::VcIdWidth-1:0] st_vc_o,
  output noc_flit_pkg::hdr_t                                      st_hdr_o
);

  localparam int NumVC     = vc_router_pkg::NumVC;
  localparam int VcIdWidth = vc_router_pkg::VcIdWidth;

  logic [NumVC-1:0]     eligible;
  logic [VcIdWidth-1:0] rr_ptr_q;

  assign eligible = hdr_head_v_i & credit_avail_i;

  // first eligible VC at or after the pointer
  always_comb begin
    logic [VcIdWidth-1:0] cand;
    sa_pop_v_o = 1'b0;
    sa_vc_o    = rr_ptr_q;
    for (int i = 0; i < NumVC; i++) begin
      cand = VcIdWidth'((int'(rr_ptr_q) + i) % NumVC);
      if (!sa_pop_v_o && eligible[cand]) begin
        sa_pop_v_o = 1'b1;
        sa_vc_o    = cand;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q   <= '0;
      st_pop_v_o <= 1'b0;
    end else begin
      st_pop_v_o <= sa_pop_v_o;
      if (sa_pop_v_o) begin
        rr_ptr_q <= (sa_vc_o == VcIdWidth'(NumVC - 1)) ? '0 : sa_vc_o + 1'b1;
      end
    end
  end

  // granted VC and its header move into ST
  always_ff @(posedge clk_i) begin
    if (sa_pop_v_o) begin
      st_vc_o  <= sa_vc_o;
      st_hdr_o <= hdr_head_i[sa_vc_o];
    end
  end

endmodule

`default_nettype wire

/* hw/flit_out_stage.sv */
/*
 * flit_out_stage
 * downstream credit tracking per VC and the registered output flit,
 * header from ST is joined with the payload head of the same VC
 */

`timescale 1ns/1ps
`default_nettype none

module flit_out_stage (
  input  wire logic                                                 clk_i,
  input  wire logic                                                 reset_i,
  // SA grant consumes a downstream credit
  input  wire logic                                                 sa_pop_v_i,
  input  wire logic                    [vc_router_pkg::VcIdWidth-1:0] sa_vc_i,
  // ST stage
  input  wire logic                                                 st_pop_v_i,
  input  wire logic                    [vc_router_pkg::VcIdWidth-1:0] st_vc_i,
  input  wire noc_flit_pkg::hdr_t                                   st_hdr_i,
  input  wire noc_flit_pkg::payload_t  [vc_router_pkg::NumVC-1:0]   payload_head_i,
  // credits from the downstream router
  input  wire logic                                                 credit_v_i,
  input  wire logic                    [vc_router_pkg::VcIdWidth-1:0] credit_vc_i,
  output logic                         [vc_router_pkg::NumVC-1:0]   credit_avail_o,
  output logic                                                      flit_v_o,
  output logic                         [vc_router_pkg::VcIdWidth-1:0] flit_vc_o,
  output noc_flit_pkg::flit_t                                       flit_o
);

  localparam int CreditWidth = vc_router_pkg::CreditWidth;
  localparam logic [CreditWidth-1:0] CreditMax = CreditWidth'(vc_router_pkg::VcDepth);

  noc_flit_pkg::flit_t flit_d;

  for (genvar v = 0; v < vc_router_pkg::NumVC; v++) begin : gen_credit
    logic                   take;
    logic                   give;
    logic [CreditWidth-1:0] count_q;

    assign take = sa_pop_v_i && (sa_vc_i == v);
    // ignore a stray credit beyond the buffer depth
    assign give = credit_v_i && (credit_vc_i == v) && (count_q != CreditMax);

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        count_q <= CreditMax;
      end else if (take && !give) begin
        count_q <= count_q - 1'b1;
      end else if (give && !take) begin
        count_q <= count_q + 1'b1;
      end
    end

    assign credit_avail_o[v] = (count_q != '0);
  end

  // reassemble the flit from the ST header and the matching payload
  always_comb begin
    flit_d.hdr     = st_hdr_i;
    flit_d.payload = payload_head_i[st_vc_i];
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      flit_v_o <= 1'b0;
    end else begin
      flit_v_o <= st_pop_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (st_pop_v_i) begin
      flit_o    <= flit_d;
      flit_vc_o <= st_vc_i;
    end
  end

endmodule

`default_nettype wire

/* hw/vc_router_port.sv */
/*
 * vc_router_port
 * one input-to-output router slice, input buffers feed switch
 * allocation, which feeds the output stage
 */

`timescale 1ns/1ps
`default_nettype none

module vc_router_port (
  input  wire logic                                      clk_i,
  input  wire logic                                      reset_i,
  // upstream
  input  wire logic     [vc_router_pkg::NumVC-1:0]       flit_v_i,
  input  wire noc_flit_pkg::flit_t                       flit_i,
  output logic                                           credit_v_o,
  output logic          [vc_router_pkg::VcIdWidth-1:0]   credit_vc_o,
  // downstream
  input  wire logic                                      credit_v_i,
  input  wire logic     [vc_router_pkg::VcIdWidth-1:0]   credit_vc_i,
  output logic                                           flit_v_o,
  output logic          [vc_router_pkg::VcIdWidth-1:0]   flit_vc_o,
  output noc_flit_pkg::flit_t                            flit_o
);

  logic                                                  sa_pop_v;
  logic                   [vc_router_pkg::VcIdWidth-1:0] sa_vc;
  logic                                                  st_pop_v;
  logic                   [vc_router_pkg::VcIdWidth-1:0] st_vc;
  noc_flit_pkg::hdr_t                                    st_hdr;
  logic                   [vc_router_pkg::NumVC-1:0]     hdr_head_v;
  noc_flit_pkg::hdr_t     [vc_router_pkg::NumVC-1:0]     hdr_head;
  noc_flit_pkg::payload_t [vc_router_pkg::NumVC-1:0]     payload_head;
  logic                   [vc_router_pkg::NumVC-1:0]     credit_avail;

  vc_input_port u_input_port (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .flit_v_i       (flit_v_i),
    .flit_i         (flit_i),
    .sa_pop_v_i     (sa_pop_v),
    .sa_vc_i        (sa_vc),
    .st_pop_v_i     (st_pop_v),
    .st_vc_i        (st_vc),
    .hdr_head_v_o   (hdr_head_v),
    .hdr_head_o     (hdr_head),
    .payload_head_o (payload_head),
    .credit_v_o     (credit_v_o),
    .credit_vc_o    (credit_vc_o)
  );

  switch_alloc u_switch_alloc (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .hdr_head_v_i   (hdr_head_v),
    .hdr_head_i     (hdr_head),
    .credit_avail_i (credit_avail),
    .sa_pop_v_o     (sa_pop_v),
    .sa_vc_o        (sa_vc),
    .st_pop_v_o     (st_pop_v),
    .st_vc_o        (st_vc),
    .st_hdr_o       (st_hdr)
  );

  flit_out_stage u_out_stage (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .sa_pop_v_i     (sa_pop_v),
    .sa_vc_i        (sa_vc),
    .st_pop_v_i     (st_pop_v),
    .st_vc_i        (st_vc),
    .st_hdr_i       (st_hdr),
    .payload_head_i (payload_head),
    .credit_v_i     (credit_v_i),
    .credit_vc_i    (credit_vc_i),
    .credit_avail_o (credit_avail),
    .flit_v_o       (flit_v_o),
    .flit_vc_o      (flit_vc_o),
    .flit_o         (flit_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_vc_router_port.sv */
/*
 * testbench for vc_router_port
 * table-driven stimulus, checked every cycle against a reference model
 * of the VC buffers, round-robin allocation and both credit loops
 */

`timescale 1ns/1ps
`default_nettype none

module tb_vc_router_port;

  localparam int NumVC      = vc_router_pkg::NumVC;
  localparam int VcIdWidth  = vc_router_pkg::VcIdWidth;
  localparam int VcDepth    = vc_router_pkg::VcDepth;
  localparam int NumSteps   = 24;
  localparam int WaitLimit  = 50;
  localparam int DrainLimit = 300;

  // per step: input VC (-1 idle), header byte, downstream credit VC (-1 none)
  localparam int StepSendVc [NumSteps] = '{-1, 2, -1, -1, -1, 0, 0, 0, 1, 1, 1, 0,
                                           0, 1, 1, 3, 2, 3, 2, 3, 2, 0, 1, 3};
  localparam logic [7:0] StepHdr [NumSteps] = '{8'h00, 8'h2a, 8'h00, 8'h00, 8'h00, 8'h05,
                                                8'h15, 8'h25, 8'h31, 8'h41, 8'h51, 8'h60,
                                                8'h70, 8'h81, 8'h91, 8'ha3, 8'hb2, 8'hc3,
                                                8'hd2, 8'he3, 8'hf2, 8'h10, 8'h21, 8'h33};
  localparam int StepRetVc [NumSteps] = '{-1, -1, -1, -1, 2, -1, -1, -1, -1, -1, -1, -1,
                                          -1, -1, -1, -1, -1, 0, 1, 0, 1, 3, 2, -1};

  logic                   clk;
  logic                   rst;
  logic [NumVC-1:0]       in_flit_v;
  noc_flit_pkg::flit_t    in_flit;
  logic                   ds_credit_v;
  logic [VcIdWidth-1:0]   ds_credit_vc;
  logic                   us_credit_v;
  logic [VcIdWidth-1:0]   us_credit_vc;
  logic                   out_flit_v;
  logic [VcIdWidth-1:0]   out_flit_vc;
  noc_flit_pkg::flit_t    out_flit;

  // reference model state
  noc_flit_pkg::flit_t mq [NumVC][$];
  int                  rr_ptr;
  int                  dcred [NumVC];
  int                  ucred [NumVC];
  int                  owed [NumVC];
  int                  out_cnt [NumVC];
  int                  ret_cnt [NumVC];
  logic                st_v_m;
  int                  st_vc_m;
  noc_flit_pkg::flit_t st_flit_m;
  logic                out_v_m;
  int                  out_vc_m;
  noc_flit_pkg::flit_t out_flit_m;
  int                  total_in;
  int                  dut_out;
  // upstream credit pulse seen in the last cycle
  logic                cred_pend;
  logic [VcIdWidth-1:0] cred_pend_vc;

  vc_router_port u_dut (
    .clk_i       (clk),
    .reset_i     (rst),
    .flit_v_i    (in_flit_v),
    .flit_i      (in_flit),
    .credit_v_o  (us_credit_v),
    .credit_vc_o (us_credit_vc),
    .credit_v_i  (ds_credit_v),
    .credit_vc_i (ds_credit_vc),
    .flit_v_o    (out_flit_v),
    .flit_vc_o   (out_flit_vc),
    .flit_o      (out_flit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    abort_run($sformatf("Error at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got));
  endtask

  // one clock edge of the router as seen from its ports
  task automatic advance_model(input int send_vc, input noc_flit_pkg::flit_t f,
                               input int give_vc);
    int grant;
    int c;
    grant = -1;
    for (int i = 0; i < NumVC; i++) begin
      c = (rr_ptr + i) % NumVC;
      if (grant < 0 && mq[c].size() > 0 && dcred[c] > 0) begin
        grant = c;
      end
    end
    out_v_m = st_v_m;
    if (st_v_m) begin
      out_vc_m   = st_vc_m;
      out_flit_m = st_flit_m;
      owed[st_vc_m]++;
    end
    if (grant >= 0) begin
      dcred[grant]--;
    end
    if (give_vc >= 0) begin
      dcred[give_vc]++;
    end
    st_v_m = (grant >= 0);
    if (grant >= 0) begin
      st_vc_m   = grant;
      st_flit_m = mq[grant].pop_front();
      rr_ptr    = (grant + 1) % NumVC;
    end
    if (send_vc >= 0) begin
      mq[send_vc].push_back(f);
      total_in++;
    end
  endtask

  task automatic check_outputs();
    if (out_flit_v === 1'b1) begin
      dut_out++;
      out_cnt[out_flit_vc]++;
      assert (out_cnt[out_flit_vc] <= VcDepth + ret_cnt[out_flit_vc])
        else abort_run("a VC sent more flits than its downstream credits allow");
    end
    assert (out_flit_v === out_v_m) else report_mismatch("flit_v_o", out_v_m, out_flit_v);
    assert (us_credit_v === st_v_m) else report_mismatch("credit_v_o", st_v_m, us_credit_v);
    if (out_v_m) begin
      assert (out_flit_vc === VcIdWidth'(out_vc_m))
        else report_mismatch("flit_vc_o", out_vc_m, out_flit_vc);
      assert (out_flit === out_flit_m) else report_mismatch("flit_o", out_flit_m, out_flit);
    end
    if (st_v_m) begin
      assert (us_credit_vc === VcIdWidth'(st_vc_m))
        else report_mismatch("credit_vc_o", st_vc_m, us_credit_vc);
    end
    // upstream registers the credit pulse and uses it from the next cycle on
    if (cred_pend) begin
      ucred[cred_pend_vc]++;
    end
    cred_pend    = us_credit_v;
    cred_pend_vc = us_credit_vc;
  endtask

  // drive one cycle of inputs, let the edge pass, then compare
  task automatic run_cycle(input int send_vc, input logic [7:0] hdr, input int give_vc);
    noc_flit_pkg::flit_t f;
    int                  give;
    f.hdr     = noc_flit_pkg::hdr_t'(hdr);
    f.payload = noc_flit_pkg::payload_t'($urandom);
    give      = -1;
    // downstream only returns credits for flits it actually holds
    if (give_vc >= 0 && owed[give_vc] > 0) begin
      give = give_vc;
      owed[give]--;
      ret_cnt[give]++;
    end
    in_flit_v = '0;
    if (send_vc >= 0) begin
      in_flit_v[send_vc] = 1'b1;
      ucred[send_vc]--;
    end
    in_flit      = f;
    ds_credit_v  = (give >= 0);
    ds_credit_vc = (give >= 0) ? VcIdWidth'(give) : '0;
    advance_model(send_vc, f, give);
    @(posedge clk);
    #1;
    check_outputs();
  endtask

  function automatic logic model_busy();
    logic busy;
    busy = st_v_m || out_v_m;
    for (int v = 0; v < NumVC; v++) begin
      busy = busy || (mq[v].size() > 0);
    end
    return busy;
  endfunction

  initial begin
    int wait_cnt;
    int give;
    int rot;
    void'($urandom(89));
    rst          = 1'b1;
    in_flit_v    = '0;
    in_flit      = '0;
    ds_credit_v  = 1'b0;
    ds_credit_vc = '0;
    rr_ptr       = 0;
    st_v_m       = 1'b0;
    out_v_m      = 1'b0;
    total_in     = 0;
    dut_out      = 0;
    cred_pend    = 1'b0;
    cred_pend_vc = '0;
    for (int v = 0; v < NumVC; v++) begin
      dcred[v]   = VcDepth;
      ucred[v]   = VcDepth;
      owed[v]    = 0;
      out_cnt[v] = 0;
      ret_cnt[v] = 0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // quiet router after reset
    repeat (4) run_cycle(-1, 8'h00, -1);

    for (int s = 0; s < NumSteps; s++) begin
      wait_cnt = 0;
      while (StepSendVc[s] >= 0 && ucred[StepSendVc[s]] == 0) begin
        if (wait_cnt == WaitLimit) begin
          abort_run("timeout waiting for an upstream credit");
        end
        wait_cnt++;
        run_cycle(-1, 8'h00, -1);
      end
      run_cycle(StepSendVc[s], StepHdr[s], StepRetVc[s]);
    end

    // drain with downstream returning credits in rotation
    wait_cnt = 0;
    rot      = 0;
    while (model_busy()) begin
      if (wait_cnt == DrainLimit) begin
        abort_run("timeout while draining the router");
      end
      wait_cnt++;
      give = -1;
      for (int i = 0; i < NumVC; i++) begin
        if (give < 0 && owed[(rot + i) % NumVC] > 0) begin
          give = (rot + i) % NumVC;
        end
      end
      rot = (rot + 1) % NumVC;
      run_cycle(-1, 8'h00, give);
    end

    assert (dut_out == total_in)
      else abort_run($sformatf("%0d flits went in but %0d came out", total_in, dut_out));
    for (int v = 0; v < NumVC; v++) begin
      assert (ucred[v] == VcDepth)
        else abort_run($sformatf("upstream credits for VC %0d did not all return", v));
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
hw/noc_flit_pkg.sv
hw/vc_router_pkg.sv
hw/vc_fifo.sv
hw/vc_input_port.sv
hw/switch_alloc.sv
hw/flit_out_stage.sv
hw/vc_router_port.sv
testbench/tb_vc_router_port.sv

/* Makefile */
# Verilator build and run for the VC router port slice

VERILATOR  ?= verilator
TOP        ?= tb_vc_router_port
RTL_TOP    ?= vc_router_port
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= TEST FAIL
PASS_MSG   ?= TEST PASS
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only
RTL_SRCS   := $(shell grep '^hw/' $(FILELIST))

.PHONY: all sim lint clean

all: sim

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
